// ==== src/rv_dmem.sv ====
`timescale 1ns/1ps

`include "rv_mem_defines.svh"

module rv_dmem
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  logic      clk,
  input  dmem_req_t req,
  output word_t     rdata
);

  localparam int DEPTH = 1 << `RV_DMEM_AWORDS;

  word_t mem [DEPTH];

  logic [`RV_DMEM_AWORDS-1:0] widx;

  // Word index, byte offset bits dropped
  // Address bits above the array size wrap around
  assign widx = req.addr[`RV_DMEM_AWORDS+1:2];

  // Byte-lane writes on the clock edge
  always_ff @(posedge clk) begin
    if (req.we) begin
      for (int i = 0; i < 4; i++) begin
        if (req.wstrb[i]) begin
          mem[widx][i*8 +: 8] <= req.wdata[i*8 +: 8];
        end
      end
    end
  end

  // Asynchronous read, zero when not reading
  assign rdata = req.ren ? mem[widx] : '0;

endmodule

// ==== src/rv_isa_pkg.sv ====
package rv_isa_pkg;

  // Basic datapath widths
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [31:0] instr_t;
  typedef logic [63:0] dword_t;
  typedef logic [3:0]  strb_t;

  // Load/store width and extension, as encoded in funct3
  typedef enum logic [2:0] {
    F3_B  = 3'b000,
    F3_H  = 3'b001,
    F3_W  = 3'b010,
    F3_BU = 3'b100,
    F3_HU = 3'b101
  } mem_f3_e;

  // Writeback result source
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_MEM = 3'd1,
    RES_PC4 = 3'd2,
    RES_TGT = 3'd3,
    RES_M   = 3'd4,
    RES_CSR = 3'd5,
    RES_MUL = 3'd6
  } res_src_e;

  // Major opcode of JAL
  localparam logic [6:0] OP_JAL = 7'b110_1111;

endpackage

// ==== src/rv_ld_fmt.sv ====
`timescale 1ns/1ps

module rv_ld_fmt
  import rv_isa_pkg::*;
(
  input  word_t       rdata,
  input  logic [1:0]  addr_lo,
  input  mem_f3_e     funct3,
  output word_t       data
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  // Addressed byte, lane chosen by both low address bits
  assign byte_sel = rdata[{addr_lo, 3'b000} +: 8];

  // Addressed halfword, bit 0 of the address is ignored
  assign half_sel = addr_lo[1] ? rdata[31:16] : rdata[15:0];

  // Extend to full width by funct3
  always_comb begin
    case (funct3)
      F3_B:    data = {{24{byte_sel[7]}}, byte_sel};
      F3_H:    data = {{16{half_sel[15]}}, half_sel};
      F3_BU:   data = {24'h00_0000, byte_sel};
      F3_HU:   data = {16'h0000, half_sel};
      // LW and anything else returns the raw word
      default: data = rdata;
    endcase
  end

endmodule

// ==== src/rv_mem_defines.svh ====
`ifndef RV_MEM_DEFINES_SVH
`define RV_MEM_DEFINES_SVH

// Data RAM depth as log2 of the number of 32-bit words
// 64 words gives 256 bytes of data memory
`define RV_DMEM_AWORDS 6

// Canonical NOP, ADDI x0, x0, 0
// Loaded into the MEM/WB instruction field at reset
`define RV_NOP_INSTR 32'h0000_0013

`endif

// ==== src/rv_mem_subsys.sv ====
`timescale 1ns/1ps

module rv_mem_subsys
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,
  input  ex_mem_t  ex_mem,
  output mem_wb_t  mem_wb,
  output word_t    result_mem,
  output word_t    load_data_mem,
  output ras_upd_t ras_upd
);

  // Request and read data between the stage and the RAM
  dmem_req_t dmem_req;
  word_t     dmem_rdata;

  // Memory-access stage with its MEM/WB register
  rv_stage_mem i_rv_stage_mem (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .ex_mem        (ex_mem),
    .dmem_req      (dmem_req),
    .dmem_rdata    (dmem_rdata),
    .mem_wb        (mem_wb),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem),
    .ras_upd       (ras_upd)
  );

  // Data RAM, combinational read
  rv_dmem i_rv_dmem (
    .clk   (clk),
    .req   (dmem_req),
    .rdata (dmem_rdata)
  );

endmodule

// ==== src/rv_mul_combine.sv ====
`timescale 1ns/1ps

module rv_mul_combine
  import rv_isa_pkg::*;
(
  input  word_t  ll,
  input  word_t  lh,
  input  word_t  hl,
  input  word_t  hh,
  output dword_t product
);

  // Partial products widened before shifting so no carry is lost
  dword_t ll_w;
  dword_t mid_w;
  dword_t hh_w;

  assign ll_w  = dword_t'(ll);
  // Cross terms share the same weight, sum them first
  assign mid_w = (dword_t'(lh) + dword_t'(hl)) << 16;
  assign hh_w  = dword_t'(hh) << 32;

  // a*b = ll + (lh + hl) * 2^16 + hh * 2^32
  assign product = ll_w + mid_w + hh_w;

endmodule

// ==== src/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

  import rv_isa_pkg::*;

  // Bundle handed over by the execute stage
  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    logic     is_jalr;
    res_src_e res_src;
    instr_t   instr;
    reg_idx_t rd;
    mem_f3_e  funct3;
    word_t    alu_result;
    word_t    rs2_data;
    word_t    pc_plus4;
    word_t    jb_target;
    word_t    csr_rdata;
    word_t    m_result;
    // Unsigned 16x16 partial products
    word_t    mul_ll;
    word_t    mul_lh;
    word_t    mul_hl;
    word_t    mul_hh;
  } ex_mem_t;

  // Bundle registered towards writeback
  typedef struct packed {
    logic     reg_write;
    res_src_e res_src;
    instr_t   instr;
    reg_idx_t rd;
    mem_f3_e  funct3;
    word_t    alu_result;
    word_t    load_data;
    word_t    pc_plus4;
    word_t    jb_target;
    word_t    csr_rdata;
    word_t    m_result;
    dword_t   product;
  } mem_wb_t;

  // Data RAM request, one address for both read and write
  typedef struct packed {
    logic  ren;
    word_t addr;
    logic  we;
    word_t wdata;
    strb_t wstrb;
  } dmem_req_t;

  // Return-address-stack update
  typedef struct packed {
    logic  push_en;
    word_t push_addr;
    logic  pop_en;
  } ras_upd_t;

endpackage

// ==== src/rv_st_fmt.sv ====
`timescale 1ns/1ps

module rv_st_fmt
  import rv_isa_pkg::*;
(
  input  word_t       rs2,
  input  logic [1:0]  addr_lo,
  input  mem_f3_e     funct3,
  input  logic        mem_write,
  output word_t       wdata,
  output strb_t       wstrb
);

  strb_t lane_strb;

  // Replicate the store data so every lane carries the right bytes
  // The strobe then picks which lanes actually get written
  always_comb begin
    case (funct3)
      F3_B: begin
        wdata     = {4{rs2[7:0]}};
        lane_strb = strb_t'(4'b0001 << addr_lo);
      end
      F3_H: begin
        wdata     = {2{rs2[15:0]}};
        // Halfword lanes follow address bit 1 only
        lane_strb = addr_lo[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        wdata     = rs2;
        lane_strb = 4'b1111;
      end
    endcase
  end

  // No lanes enabled unless this is a store
  assign wstrb = mem_write ? lane_strb : 4'b0000;

endmodule

// ==== src/rv_stage_mem.sv ====
`timescale 1ns/1ps

`include "rv_mem_defines.svh"

module rv_stage_mem
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      stall,
  input  ex_mem_t   ex_mem,
  output dmem_req_t dmem_req,
  input  word_t     dmem_rdata,
  output mem_wb_t   mem_wb,
  output word_t     result_mem,
  output word_t     load_data_mem,
  output ras_upd_t  ras_upd
);

  word_t    st_wdata;
  strb_t    st_wstrb;
  dword_t   product;
  logic     is_jal;
  reg_idx_t instr_rd;

  // Store data and byte strobes from rs2 and the low address bits
  rv_st_fmt i_st_fmt (
    .rs2       (ex_mem.rs2_data),
    .addr_lo   (ex_mem.alu_result[1:0]),
    .funct3    (ex_mem.funct3),
    .mem_write (ex_mem.mem_write),
    .wdata     (st_wdata),
    .wstrb     (st_wstrb)
  );

  // RAM request, ALU result is the effective address for both directions
  always_comb begin
    dmem_req.ren   = ex_mem.mem_read;
    dmem_req.addr  = ex_mem.alu_result;
    dmem_req.we    = ex_mem.mem_write;
    dmem_req.wdata = st_wdata;
    dmem_req.wstrb = st_wstrb;
  end

  // RAM read is combinational so loads are formatted here
  rv_ld_fmt i_ld_fmt (
    .rdata   (dmem_rdata),
    .addr_lo (ex_mem.alu_result[1:0]),
    .funct3  (ex_mem.funct3),
    .data    (load_data_mem)
  );

  // Forwarding result
  // Multiply completes in writeback so it is never forwarded from here
  always_comb begin
    case (ex_mem.res_src)
      RES_M:   result_mem = ex_mem.m_result;
      RES_PC4: result_mem = ex_mem.pc_plus4;
      RES_TGT: result_mem = ex_mem.jb_target;
      default: result_mem = ex_mem.alu_result;
    endcase
  end

  // Call/return detection from the instruction word itself
  assign is_jal   = (ex_mem.instr[6:0] == OP_JAL);
  assign instr_rd = ex_mem.instr[11:7];

  always_comb begin
    // Calls link into a non-zero rd
    ras_upd.push_en   = (is_jal || ex_mem.is_jalr) && (instr_rd != 5'd0);
    ras_upd.push_addr = ex_mem.pc_plus4;
    // Every JALR is treated as a return
    ras_upd.pop_en    = ex_mem.is_jalr;
  end

  // Full 64-bit unsigned product from the four partial products
  rv_mul_combine i_mul_combine (
    .ll      (ex_mem.mul_ll),
    .lh      (ex_mem.mul_lh),
    .hl      (ex_mem.mul_hl),
    .hh      (ex_mem.mul_hh),
    .product (product)
  );

  // MEM/WB register, holds while stalled
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mem_wb       <= '0;
      mem_wb.instr <= `RV_NOP_INSTR;
    end else if (!stall) begin
      mem_wb.reg_write  <= ex_mem.reg_write;
      mem_wb.res_src    <= ex_mem.res_src;
      mem_wb.instr      <= ex_mem.instr;
      mem_wb.rd         <= ex_mem.rd;
      mem_wb.funct3     <= ex_mem.funct3;
      mem_wb.alu_result <= ex_mem.alu_result;
      mem_wb.load_data  <= load_data_mem;
      mem_wb.pc_plus4   <= ex_mem.pc_plus4;
      mem_wb.jb_target  <= ex_mem.jb_target;
      mem_wb.csr_rdata  <= ex_mem.csr_rdata;
      mem_wb.m_result   <= ex_mem.m_result;
      mem_wb.product    <= product;
    end
  end

endmodule

// ==== tb/rv_mem_subsys_asserts.sv ====
`timescale 1ns/1ps

module rv_mem_subsys_asserts
  import rv_isa_pkg::*, rv_pipe_pkg::*;
(
  input logic      clk,
  input logic      rst_n,
  input logic      stall,
  input ex_mem_t   ex_mem,
  input dmem_req_t dmem_req,
  input mem_wb_t   mem_wb,
  input ras_upd_t  ras_upd
);

  // Byte lanes only open for a store
  a_strb_needs_we: assert property (@(posedge clk) !dmem_req.we |-> dmem_req.wstrb == '0)
    else $error("wstrb active while we is low");

  // Push and pop together only for a linking JALR
  a_push_pop_jalr: assert property (@(posedge clk)
    (ras_upd.push_en && ras_upd.pop_en) |-> ex_mem.is_jalr)
    else $error("RAS push and pop together without is_jalr");

  // MEM/WB register frozen across a stalled cycle
  a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n) stall |=> $stable(mem_wb))
    else $error("mem_wb changed while stall was high");

  // First cycle out of reset carries no register write
  a_reset_bubble: assert property (@(posedge clk) $rose(rst_n) |-> !mem_wb.reg_write)
    else $error("mem_wb reg_write high right after reset");

endmodule

// ==== tb/rv_mem_subsys_tb.sv ====
`timescale 1ns/1ps

`include "rv_mem_defines.svh"

module rv_mem_subsys_tb
  import rv_isa_pkg::*, rv_pipe_pkg::*;
();

  // Step kinds, first column of the test file
  localparam logic [3:0] K_STORE  = 4'd0;
  localparam logic [3:0] K_LOAD   = 4'd1;
  localparam logic [3:0] K_FWD    = 4'd2;
  localparam logic [3:0] K_JAL    = 4'd3;
  localparam logic [3:0] K_JALR   = 4'd4;
  localparam logic [3:0] K_MUL    = 4'd5;
  localparam logic [3:0] K_BUBBLE = 4'hf;

  // sel is funct3, res_src or rd depending on the kind
  typedef struct packed {
    logic [3:0] kind;
    logic [4:0] sel;
    word_t      addr;
    word_t      data;
    word_t      a;
    word_t      b;
    logic       stall;
    word_t      exp;
  } step_t;

  logic     clk;
  logic     rst_n;
  logic     stall;
  ex_mem_t  ex_mem;
  mem_wb_t  mem_wb;
  word_t    result_mem;
  word_t    load_data_mem;
  ras_upd_t ras_upd;

  step_t    steps[$];
  // Expected RAM contents, one word per RAM word
  word_t    shadow [1 << `RV_DMEM_AWORDS];

  rv_mem_subsys i_rv_mem_subsys (
    .clk           (clk),
    .rst_n         (rst_n),
    .stall         (stall),
    .ex_mem        (ex_mem),
    .mem_wb        (mem_wb),
    .result_mem    (result_mem),
    .load_data_mem (load_data_mem),
    .ras_upd       (ras_upd)
  );

  bind rv_mem_subsys rv_mem_subsys_asserts i_rv_mem_subsys_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .ex_mem   (ex_mem),
    .dmem_req (dmem_req),
    .mem_wb   (mem_wb),
    .ras_upd  (ras_upd)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic abort_run(string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_dword(string name, dword_t got, dword_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_ras(ras_upd_t got, ras_upd_t exp);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: ras_upd push %b pop %b addr %h, expected %b %b %h",
                          $time, got.push_en, got.pop_en, got.push_addr,
                          exp.push_en, exp.pop_en, exp.push_addr));
    end
  endtask

  // Control fields of the MEM/WB register
  task automatic check_wb_ctrl(mem_wb_t got, mem_wb_t exp);
    string fields;
    if (got.reg_write !== exp.reg_write || got.rd !== exp.rd ||
        got.res_src !== exp.res_src || got.funct3 !== exp.funct3) begin
      fields = $sformatf("reg_write %b rd %0d res_src %0d funct3 %0d, expected %b %0d %0d %0d",
                         got.reg_write, got.rd, got.res_src, got.funct3,
                         exp.reg_write, exp.rd, exp.res_src, exp.funct3);
      abort_run($sformatf("FAILED at %0t: mem_wb %s", $time, fields));
    end
  endtask

  // Whole MEM/WB bundle against the expected one
  // Load data and product only carry meaning for their own step kinds
  task automatic compare_mem_wb(mem_wb_t exp, logic [3:0] kind);
    check_wb_ctrl(mem_wb, exp);
    check_word("mem_wb.instr", mem_wb.instr, exp.instr);
    check_word("mem_wb.alu_result", mem_wb.alu_result, exp.alu_result);
    check_word("mem_wb.pc_plus4", mem_wb.pc_plus4, exp.pc_plus4);
    check_word("mem_wb.jb_target", mem_wb.jb_target, exp.jb_target);
    check_word("mem_wb.csr_rdata", mem_wb.csr_rdata, exp.csr_rdata);
    check_word("mem_wb.m_result", mem_wb.m_result, exp.m_result);
    if (kind inside {K_LOAD, K_BUBBLE}) begin
      check_word("mem_wb.load_data", mem_wb.load_data, exp.load_data);
    end
    if (kind inside {K_MUL, K_BUBBLE}) begin
      check_dword("mem_wb.product", mem_wb.product, exp.product);
    end
  endtask

  // Reads every step after the two header lines
  task automatic load_tests();
    int    fd;
    string line;
    int    kind;
    int    sel;
    int    st;
    word_t addr;
    word_t data;
    word_t a;
    word_t b;
    word_t exp;
    step_t s;
    fd = $fopen("tb/rv_mem_tests.txt", "r");
    if (fd == 0) begin
      abort_run("Could not open the test file tb/rv_mem_tests.txt");
    end
    void'($fgets(line, fd));
    void'($fgets(line, fd));
    while ($fscanf(fd, "%h %h %h %h %h %h %h %h", kind, sel, addr, data, a, b, st, exp) == 8) begin
      if (kind > K_MUL) begin
        abort_run($sformatf("Unknown step kind %0d in the test file", kind));
      end
      s = {kind[3:0], sel[4:0], addr, data, a, b, st[0], exp};
      steps.push_back(s);
    end
    $fclose(fd);
  endtask

  task automatic watchdog(int cycles);
    repeat (cycles) @(posedge clk);
    abort_run("Run timed out before all test steps finished");
  endtask

  // Old word with the lanes that a store writes replaced
  function automatic word_t store_lanes(word_t old, logic [2:0] f3, logic [1:0] lo, word_t d);
    word_t w;
    w = old;
    for (int i = 0; i < 4; i++) begin
      case (f3)
        3'b000: if (i == lo) w[i*8 +: 8] = d[7:0];
        3'b001: if (i / 2 == lo[1]) w[i*8 +: 8] = d[(i % 2)*8 +: 8];
        default: w[i*8 +: 8] = d[i*8 +: 8];
      endcase
    end
    return w;
  endfunction

  function automatic ex_mem_t build_bundle(step_t s, int idx);
    ex_mem_t ex;
    ex            = '0;
    ex.instr      = `RV_NOP_INSTR;
    ex.rd         = reg_idx_t'(idx);
    ex.funct3     = F3_W;
    ex.res_src    = RES_ALU;
    ex.reg_write  = (s.kind inside {K_LOAD, K_FWD, K_JAL, K_JALR, K_MUL});
    ex.alu_result = s.addr;
    ex.pc_plus4   = s.addr;
    ex.rs2_data   = $urandom;
    ex.csr_rdata  = $urandom;
    case (s.kind)
      K_STORE: begin
        ex.mem_write = 1'b1;
        ex.funct3    = mem_f3_e'(s.sel[2:0]);
        ex.rs2_data  = s.data;
      end
      K_LOAD: begin
        ex.mem_read = 1'b1;
        ex.funct3   = mem_f3_e'(s.sel[2:0]);
        ex.res_src  = RES_MEM;
      end
      K_FWD: begin
        ex.res_src   = res_src_e'(s.sel[2:0]);
        ex.m_result  = s.data;
        ex.pc_plus4  = s.a;
        ex.jb_target = s.b;
      end
      K_JAL: begin
        ex.res_src = RES_PC4;
        ex.rd      = s.sel;
        ex.instr   = {20'h0_0000, s.sel, OP_JAL};
      end
      K_JALR: begin
        ex.res_src = RES_PC4;
        ex.is_jalr = 1'b1;
        ex.rd      = s.sel;
        // jalr rd, 0(ra)
        ex.instr   = {12'h000, 5'd1, 3'b000, s.sel, 7'b110_0111};
      end
      K_MUL: begin
        // Unsigned 16x16 halves of the two operands
        ex.res_src = RES_MUL;
        ex.mul_ll  = word_t'(s.a[15:0]) * word_t'(s.b[15:0]);
        ex.mul_lh  = word_t'(s.a[15:0]) * word_t'(s.b[31:16]);
        ex.mul_hl  = word_t'(s.a[31:16]) * word_t'(s.b[15:0]);
        ex.mul_hh  = word_t'(s.a[31:16]) * word_t'(s.b[31:16]);
      end
      default: ;
    endcase
    return ex;
  endfunction

  initial begin
    step_t      s;
    ex_mem_t    ex;
    ras_upd_t   ras_exp;
    mem_wb_t    held;
    mem_wb_t    pend;
    logic [3:0] held_kind;
    logic [3:0] pend_kind;
    logic       pend_stall;
    logic       pend_valid;
    void'($urandom(74));
    rst_n        = 1'b0;
    stall        = 1'b0;
    ex_mem       = '0;
    ex_mem.instr = `RV_NOP_INSTR;
    load_tests();
    fork
      watchdog(steps.size() * 4 + 20);
    join_none
    // Reset leaves all zero except the NOP instruction
    held       = '0;
    held.instr = `RV_NOP_INSTR;
    held_kind  = K_BUBBLE;
    pend       = '0;
    pend_kind  = K_BUBBLE;
    pend_stall = 1'b0;
    pend_valid = 1'b0;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    compare_mem_wb(held, held_kind);
    // One extra bubble at the end flushes the last step into mem_wb
    for (int idx = 0; idx <= steps.size(); idx++) begin
      s = '0;
      s.kind = K_BUBBLE;
      if (idx < steps.size()) begin
        s = steps[idx];
      end
      ex = build_bundle(s, idx);
      @(posedge clk);
      ex_mem <= ex;
      stall  <= s.stall;
      @(negedge clk);
      // mem_wb shows the previous step, or keeps older contents after a stall
      if (pend_valid && !pend_stall) begin
        held      = pend;
        held_kind = pend_kind;
      end
      compare_mem_wb(held, held_kind);
      // Combinational outputs of the step just presented
      ras_exp.push_en   = (s.kind inside {K_JAL, K_JALR}) && s.exp[1];
      ras_exp.pop_en    = (s.kind inside {K_JAL, K_JALR}) && s.exp[0];
      ras_exp.push_addr = ex.pc_plus4;
      check_ras(ras_upd, ras_exp);
      case (s.kind)
        K_STORE: begin
          shadow[s.addr[`RV_DMEM_AWORDS+1:2]] =
            store_lanes(shadow[s.addr[`RV_DMEM_AWORDS+1:2]], s.sel[2:0], s.addr[1:0], s.data);
        end
        K_LOAD: begin
          check_word("load_data_mem", load_data_mem, s.exp);
          if (s.sel[2:0] == 3'b010) begin
            check_word("load word vs shadow", load_data_mem, shadow[s.addr[`RV_DMEM_AWORDS+1:2]]);
          end
        end
        K_FWD: check_word("result_mem", result_mem, s.exp);
        default: ;
      endcase
      // Passthrough fields come straight from the bundle that was driven
      pend            = '0;
      pend.reg_write  = ex.reg_write;
      pend.res_src    = ex.res_src;
      pend.instr      = ex.instr;
      pend.rd         = ex.rd;
      pend.funct3     = ex.funct3;
      pend.alu_result = ex.alu_result;
      pend.load_data  = s.exp;
      pend.pc_plus4   = ex.pc_plus4;
      pend.jb_target  = ex.jb_target;
      pend.csr_rdata  = ex.csr_rdata;
      pend.m_result   = ex.m_result;
      pend.product    = dword_t'(s.a) * dword_t'(s.b);
      pend_kind       = s.kind;
      pend_stall      = s.stall;
      pend_valid      = 1'b1;
    end
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== tb/rv_mem_tests.txt ====
# kind sel addr data a b stall exp, all hex
# kind 0 store 1 load 2 forward 3 jal 4 jalr 5 multiply; sel is funct3, res_src or rd
0 2 00000040 11223344 00000000 00000000 0 00000000
0 2 00000044 a5b6c7d8 00000000 00000000 0 00000000
0 0 00000041 1234567f 00000000 00000000 0 00000000
0 0 00000043 00000080 00000000 00000000 0 00000000
0 1 00000040 abcd7f01 00000000 00000000 0 00000000
0 1 00000046 0000f00d 00000000 00000000 0 00000000
1 2 00000040 00000000 00000000 00000000 0 80227f01
1 2 00000044 00000000 00000000 00000000 0 f00dc7d8
1 0 00000040 00000000 00000000 00000000 0 00000001
1 0 00000041 00000000 00000000 00000000 0 0000007f
1 0 00000042 00000000 00000000 00000000 0 00000022
1 0 00000043 00000000 00000000 00000000 0 ffffff80
1 4 00000044 00000000 00000000 00000000 0 000000d8
1 4 00000045 00000000 00000000 00000000 0 000000c7
1 4 00000046 00000000 00000000 00000000 0 0000000d
1 4 00000047 00000000 00000000 00000000 0 000000f0
1 1 00000040 00000000 00000000 00000000 0 00007f01
1 1 00000042 00000000 00000000 00000000 0 ffff8022
1 5 00000044 00000000 00000000 00000000 0 0000c7d8
1 5 00000046 00000000 00000000 00000000 0 0000f00d
2 0 00001000 22222222 33333333 44444444 0 00001000
2 1 00001010 22222222 33333333 44444444 0 00001010
2 2 00001020 22222222 33333333 44444444 0 33333333
2 3 00001030 22222222 33333333 44444444 1 44444444
2 4 00001040 22222222 33333333 44444444 0 22222222
2 5 00001050 22222222 33333333 44444444 0 00001050
2 6 00001060 22222222 33333333 44444444 0 00001060
3 01 00002004 00000000 00000000 00000000 0 00000002
3 00 00002008 00000000 00000000 00000000 0 00000000
4 01 0000200c 00000000 00000000 00000000 0 00000003
4 00 00002010 00000000 00000000 00000000 0 00000001
5 0 00000000 00000000 ffffffff ffffffff 0 00000000
5 0 00000000 00000000 12345678 9abcdef0 0 00000000
5 0 00000000 00000000 80000000 00000003 0 00000000

// ==== vlog.f ====
+incdir+src
src/rv_isa_pkg.sv
src/rv_pipe_pkg.sv
src/rv_st_fmt.sv
src/rv_ld_fmt.sv
src/rv_mul_combine.sv
src/rv_stage_mem.sv
src/rv_dmem.sv
src/rv_mem_subsys.sv
tb/rv_mem_subsys_asserts.sv
tb/rv_mem_subsys_tb.sv
